//--- rtl/hex_font.svh
`ifndef HEX_FONT_SVH
`define HEX_FONT_SVH

// 5x7 hex font, msb of the returned row is the leftmost pixel
// rows 0..6 hold the glyph, row 7 is the blank gap under it
function automatic logic [4:0] glyph_row(input logic [3:0] nibble, input logic [2:0] row);
    logic [34:0] g;  // seven rows of five, row 0 in the top bits
    case (nibble)
        4'h0: g = {5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110};
        4'h1: g = {5'b00100, 5'b01100, 5'b00100, 5'b00100, 5'b00100, 5'b00100, 5'b01110};
        4'h2: g = {5'b01110, 5'b10001, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b11111};
        4'h3: g = {5'b11111, 5'b00010, 5'b00100, 5'b00010, 5'b00001, 5'b10001, 5'b01110};
        4'h4: g = {5'b00010, 5'b00110, 5'b01010, 5'b10010, 5'b11111, 5'b00010, 5'b00010};
        4'h5: g = {5'b11111, 5'b10000, 5'b11110, 5'b00001, 5'b00001, 5'b10001, 5'b01110};
        4'h6: g = {5'b00110, 5'b01000, 5'b10000, 5'b11110, 5'b10001, 5'b10001, 5'b01110};
        4'h7: g = {5'b11111, 5'b00001, 5'b00010, 5'b00100, 5'b01000, 5'b01000, 5'b01000};
        4'h8: g = {5'b01110, 5'b10001, 5'b10001, 5'b01110, 5'b10001, 5'b10001, 5'b01110};
        4'h9: g = {5'b01110, 5'b10001, 5'b10001, 5'b01111, 5'b00001, 5'b00010, 5'b01100};
        4'ha: g = {5'b01110, 5'b10001, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001};
        4'hb: g = {5'b11110, 5'b10001, 5'b10001, 5'b11110, 5'b10001, 5'b10001, 5'b11110};
        4'hc: g = {5'b01110, 5'b10001, 5'b10000, 5'b10000, 5'b10000, 5'b10001, 5'b01110};
        4'hd: g = {5'b11100, 5'b10010, 5'b10001, 5'b10001, 5'b10001, 5'b10010, 5'b11100};
        4'he: g = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b11111};
        default: g = {5'b11111, 5'b10000, 5'b10000, 5'b11110, 5'b10000, 5'b10000, 5'b10000};
    endcase
    if (row == 3'd7)
    begin
        glyph_row = 5'b00000;
    end
    else
    begin
        glyph_row = g[34 - 5 * row -: 5];
    end
endfunction

`endif

//--- rtl/hex_panel_pkg.sv
package hex_panel_pkg;

    // horizontal panel timing, in pixel clocks
    localparam int h_active = 480;
    localparam int h_front  = 24;
    localparam int h_pulse  = 48;
    localparam int h_back   = 72;
    localparam int h_total  = h_active + h_front + h_pulse + h_back;  // 624

    // vertical panel timing, in lines
    localparam int v_active = 272;
    localparam int v_front  = 1;
    localparam int v_pulse  = 3;
    localparam int v_back   = 19;
    localparam int v_total  = v_active + v_front + v_pulse + v_back;  // 295

    localparam int beam_bits   = 10;   // width of beam_x and beam_y
    localparam int status_bits = 256;

    // text block layout
    localparam int digits_per_row = 32;
    localparam int text_rows      = 2;
    localparam int cell_w         = 6;
    localparam int cell_h         = 8;
    localparam int scale_shift    = 1;  // every cell pixel doubled
    localparam int glyph_w        = 5;
    localparam int glyph_h        = 7;
    localparam int col_bits       = $clog2(digits_per_row);
    localparam int row_bits       = $clog2(text_rows);
    localparam int cell_bits      = 3;  // holds a position inside one cell
    localparam int text_w         = (digits_per_row * cell_w) << scale_shift;  // 384
    localparam int text_h         = (text_rows * cell_h) << scale_shift;       // 32

    // rgb565 per text row: yellow, cyan
    localparam logic [15:0] row_colour [text_rows] = '{16'hffe0, 16'h07ff};

    // clocks from beam position to colour, then to lane words
    localparam int render_latency = 2;
    localparam int pack_latency   = 1;

endpackage

//--- rtl/panel_timing.sv
`timescale 1ns/1ps

module panel_timing
(
    input  logic                                clk_25mhz,
    input  logic                                arst_n,
    output logic [hex_panel_pkg::beam_bits-1:0] beam_x,
    output logic [hex_panel_pkg::beam_bits-1:0] beam_y,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                blank,
    output logic                                frame_start
);
    import hex_panel_pkg::*;

    // sync windows on the beam counters
    localparam logic [beam_bits-1:0] x_last   = beam_bits'(h_total - 1);
    localparam logic [beam_bits-1:0] y_last   = beam_bits'(v_total - 1);
    localparam logic [beam_bits-1:0] hs_first = beam_bits'(h_active + h_front);
    localparam logic [beam_bits-1:0] hs_end   = beam_bits'(h_active + h_front + h_pulse);
    localparam logic [beam_bits-1:0] vs_first = beam_bits'(v_active + v_front);
    localparam logic [beam_bits-1:0] vs_end   = beam_bits'(v_active + v_front + v_pulse);
    localparam logic [beam_bits-1:0] x_vis    = beam_bits'(h_active);
    localparam logic [beam_bits-1:0] y_vis    = beam_bits'(v_active);

    logic [beam_bits-1:0] x_next;
    logic [beam_bits-1:0] y_next;
    logic                 hsync_next;
    logic                 vsync_next;
    logic                 blank_next;
    logic                 wrap_next;

    // position of the next clock
    always_comb
    begin
        x_next = beam_x + 1'b1;
        y_next = beam_y;
        if (beam_x == x_last)
        begin
            x_next = '0;
            if (beam_y == y_last)
            begin
                y_next = '0;
            end
            else
            begin
                y_next = beam_y + 1'b1;
            end
        end
    end

    // decode the levels for that same position, so they register together
    always_comb
    begin
        hsync_next = (x_next >= hs_first) && (x_next < hs_end);
        vsync_next = (y_next >= vs_first) && (y_next < vs_end);
        blank_next = (x_next >= x_vis) || (y_next >= y_vis);
        wrap_next  = (x_next == '0) && (y_next == '0);
    end

    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            beam_x      <= '0;
            beam_y      <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            blank       <= 1'b0;  // pixel 0,0 is visible
            frame_start <= 1'b0;
        end
        else
        begin
            beam_x      <= x_next;
            beam_y      <= y_next;
            hsync       <= hsync_next;
            vsync       <= vsync_next;
            blank       <= blank_next;
            frame_start <= wrap_next;  // high while the beam sits at 0,0
        end
    end

endmodule

//--- rtl/status_word.sv
`timescale 1ns/1ps

module status_word
(
    input  logic                                  clk_25mhz,
    input  logic                                  arst_n,
    input  logic [6:0]                            btn,
    input  logic                                  frame_start,
    output logic [hex_panel_pkg::status_bits-1:0] display
);
    import hex_panel_pkg::*;

    logic [63:0]            frame_cnt64;
    logic [31:0]            frame_cnt32;
    logic [status_bits-1:0] snapshot;

    // word layout as shown on the panel
    always_comb
    begin
        snapshot = '0;
        for (int i = 0; i < 7; i++)
        begin
            snapshot[4 * i] = btn[i];  // one button per digit
        end
        snapshot[58:52]   = btn;
        snapshot[127:64]  = frame_cnt64;
        snapshot[159:128] = frame_cnt32;
    end

    // one load per frame keeps the picture free of tearing
    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame_cnt64 <= '0;
            frame_cnt32 <= '0;
            display     <= '0;
        end
        else if (frame_start)
        begin
            display     <= snapshot;
            frame_cnt64 <= frame_cnt64 + 64'd1;  // advance after the load
            frame_cnt32 <= frame_cnt32 + 32'd1;
        end
    end

endmodule

//--- rtl/hex_glyph_render.sv
`timescale 1ns/1ps

module hex_glyph_render
(
    input  logic                                  clk_25mhz,
    input  logic                                  arst_n,
    input  logic [hex_panel_pkg::beam_bits-1:0]   beam_x,
    input  logic [hex_panel_pkg::beam_bits-1:0]   beam_y,
    input  logic [hex_panel_pkg::status_bits-1:0] display,
    output logic [7:0]                            red,
    output logic [7:0]                            green,
    output logic [7:0]                            blue
);
    import hex_panel_pkg::*;

    `include "hex_font.svh"

    logic [beam_bits-1:0] half_x;
    logic [beam_bits-1:0] half_y;
    logic [beam_bits-1:0] col_full;
    logic [beam_bits-1:0] row_full;
    logic [beam_bits-1:0] cell_x_full;
    logic [beam_bits-1:0] cell_y_full;
    logic                 in_text;

    // stage 1 registers
    logic                 s1_in_text;
    logic [col_bits-1:0]  s1_col;
    logic [row_bits-1:0]  s1_row;
    logic [cell_bits-1:0] s1_cell_x;
    logic [cell_bits-1:0] s1_cell_y;

    // stage 2 decode
    logic [row_bits+col_bits-1:0] digit;
    logic [3:0]                   nibble;
    logic [glyph_w-1:0]           glyph;
    logic                         lit;
    logic [15:0]                  colour;

    // undo the pixel doubling, then split into cell and position in cell
    always_comb
    begin
        half_x      = beam_x >> scale_shift;
        half_y      = beam_y >> scale_shift;
        col_full    = half_x / beam_bits'(cell_w);
        cell_x_full = half_x % beam_bits'(cell_w);
        row_full    = half_y / beam_bits'(cell_h);
        cell_y_full = half_y % beam_bits'(cell_h);
        in_text     = (beam_x < beam_bits'(text_w)) && (beam_y < beam_bits'(text_h));
    end

    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s1_in_text <= 1'b0;
            s1_col     <= '0;
            s1_row     <= '0;
            s1_cell_x  <= '0;
            s1_cell_y  <= '0;
        end
        else
        begin
            s1_in_text <= in_text;
            s1_col     <= col_full[col_bits-1:0];  // only meaningful inside the block
            s1_row     <= row_full[row_bits-1:0];
            s1_cell_x  <= cell_x_full[cell_bits-1:0];
            s1_cell_y  <= cell_y_full[cell_bits-1:0];
        end
    end

    // digits_per_row is a power of two, so row and column simply concatenate
    always_comb
    begin
        digit  = {s1_row, s1_col};
        nibble = display[{digit, 2'b00} +: 4];  // column 0 shows the lowest nibble
        glyph  = glyph_row(nibble, s1_cell_y);
        lit    = 1'b0;
        if (s1_in_text && (s1_cell_x < cell_bits'(glyph_w)) && (s1_cell_y < cell_bits'(glyph_h)))
        begin
            lit = glyph[glyph_w - 1 - int'(s1_cell_x)];
        end
        colour = row_colour[s1_row];
    end

    // rgb565 widened by repeating the lowest bit of each channel
    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (lit)
        begin
            red   <= {colour[15:11], {3{colour[11]}}};
            green <= {colour[10:5], {2{colour[5]}}};
            blue  <= {colour[4:0], {3{colour[0]}}};
        end
        else
        begin
            red   <= '0;  // background is black
            green <= '0;
            blue  <= '0;
        end
    end

endmodule

//--- rtl/lvds_lane_packer.sv
`timescale 1ns/1ps

module lvds_lane_packer
(
    input  logic       clk_25mhz,
    input  logic       arst_n,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       blank,
    input  logic [7:0] red,
    input  logic [7:0] green,
    input  logic [7:0] blue,
    output logic [6:0] lane0,
    output logic [6:0] lane1,
    output logic [6:0] lane2,
    output logic [6:0] lane3
);
    import hex_panel_pkg::*;

    // {hsync, vsync, blank} delayed to meet the rendered colour
    logic [2:0] ctrl_pipe [render_latency];
    logic       hs_d;
    logic       vs_d;
    logic       de_d;

    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < render_latency; i++)
            begin
                ctrl_pipe[i] <= 3'b001;  // blank while the pipeline fills
            end
        end
        else
        begin
            ctrl_pipe[0] <= {hsync, vsync, blank};
            for (int i = 1; i < render_latency; i++)
            begin
                ctrl_pipe[i] <= ctrl_pipe[i-1];
            end
        end
    end

    assign hs_d = ctrl_pipe[render_latency-1][2];
    assign vs_d = ctrl_pipe[render_latency-1][1];
    assign de_d = ~ctrl_pipe[render_latency-1][0];  // data enable

    // bit 6 of each lane is the first one shifted out
    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lane0 <= '0;
            lane1 <= '0;
            lane2 <= '0;
            lane3 <= '0;
        end
        else
        begin
            lane0 <= {green[0], red[5:0]};
            lane1 <= {blue[1:0], green[5:1]};
            lane2 <= {de_d, vs_d, hs_d, blue[5:2]};
            lane3 <= {1'b0, blue[7:6], green[7:6], red[7:6]};
        end
    end

endmodule

//--- rtl/hex_panel_top.sv
`timescale 1ns/1ps

module hex_panel_top
(
    input  logic       clk_25mhz,
    input  logic       arst_n,
    input  logic [6:0] btn,
    output logic [7:0] led,
    output logic [6:0] lane0,
    output logic [6:0] lane1,
    output logic [6:0] lane2,
    output logic [6:0] lane3,
    output logic       wifi_gpio0
);
    import hex_panel_pkg::*;

    logic [beam_bits-1:0]   beam_x;
    logic [beam_bits-1:0]   beam_y;
    logic                   hsync;
    logic                   vsync;
    logic                   blank;
    logic                   frame_start;
    logic [status_bits-1:0] display;
    logic [7:0]             red;
    logic [7:0]             green;
    logic [7:0]             blue;

    panel_timing u_timing (
        .clk_25mhz   (clk_25mhz),
        .arst_n      (arst_n),
        .beam_x      (beam_x),
        .beam_y      (beam_y),
        .hsync       (hsync),
        .vsync       (vsync),
        .blank       (blank),
        .frame_start (frame_start)
    );

    status_word u_status (
        .clk_25mhz   (clk_25mhz),
        .arst_n      (arst_n),
        .btn         (btn),
        .frame_start (frame_start),
        .display     (display)
    );

    hex_glyph_render u_render (
        .clk_25mhz (clk_25mhz),
        .arst_n    (arst_n),
        .beam_x    (beam_x),
        .beam_y    (beam_y),
        .display   (display),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    lvds_lane_packer u_packer (
        .clk_25mhz (clk_25mhz),
        .arst_n    (arst_n),
        .hsync     (hsync),
        .vsync     (vsync),
        .blank     (blank),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lane0     (lane0),
        .lane1     (lane1),
        .lane2     (lane2),
        .lane3     (lane3)
    );

    assign led[0]     = vsync;  // raw timing levels, not delayed
    assign led[1]     = hsync;
    assign led[2]     = blank;
    assign led[7:3]   = btn[4:0];
    assign wifi_gpio0 = btn[0];  // btn0 hands the board over to the esp32

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
    output logic clk_25mhz,
    output logic arst_n
);

    initial
    begin
        clk_25mhz = 1'b0;
        forever
        begin
            #20 clk_25mhz = ~clk_25mhz;  // 40 ns period
        end
    end

    // reset held over the first five rising edges
    initial
    begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk_25mhz);
        #2 arst_n = 1'b1;
    end

endmodule

//--- bench/hex_panel_sva.sv
`timescale 1ns/1ps

module hex_panel_sva
(
    input logic clk_25mhz,
    input logic arst_n,
    input logic hsync,
    input logic vsync,
    input logic blank,
    input logic frame_start
);
    import hex_panel_pkg::*;

    int hs_run;  // clocks hsync has been high so far

    always_ff @(posedge clk_25mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hs_run <= 0;
        end
        else if (hsync)
        begin
            hs_run <= hs_run + 1;
        end
        else
        begin
            hs_run <= 0;
        end
    end

    hsync_width: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        $fell(hsync) |-> (hs_run == h_pulse))
        else $error("hsync pulse lasted %0d clocks instead of %0d", hs_run, h_pulse);

    frame_start_single: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        frame_start |=> !frame_start)
        else $error("frame_start stayed high for more than one clock");

    sync_in_blank: assert property (@(posedge clk_25mhz) disable iff (!arst_n)
        (hsync || vsync) |-> blank)
        else $error("a sync level is high outside the blanking interval");

endmodule

bind panel_timing hex_panel_sva u_sva (
    .clk_25mhz   (clk_25mhz),
    .arst_n      (arst_n),
    .hsync       (hsync),
    .vsync       (vsync),
    .blank       (blank),
    .frame_start (frame_start)
);

//--- bench/hex_panel_tb.sv
`timescale 1ns/1ps

module hex_panel_tb;
    import hex_panel_pkg::*;

    // the font is declared inside each module that uses it
    `undef HEX_FONT_SVH
    `include "hex_font.svh"

    localparam int frame_clocks = h_total * v_total;               // 184080
    localparam int out_delay    = render_latency + pack_latency;   // beam to lanes
    localparam int run_limit    = 4 * frame_clocks + 2000;

    logic       clk_25mhz;
    logic       arst_n;
    logic [6:0] btn;
    logic [7:0] led;
    logic [6:0] lane0;
    logic [6:0] lane1;
    logic [6:0] lane2;
    logic [6:0] lane3;
    logic       wifi_gpio0;

    int          cycle = 0;        // clocks since reset release
    int          timeout_cnt = 0;
    logic [31:0] rng_state;
    logic [6:0]  btn_hist [4];     // pattern shown by snapshot n
    int          check_count = 0;
    int          err_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    // lane2 decode state
    logic prev_hs = 1'b0;
    logic prev_vs = 1'b0;
    int   hs_len = 0;
    int   hs_gap = 0;
    int   hs_rises = 0;
    int   de_len = 0;
    int   de_lines = 0;
    int   vs_lines = 0;
    int   decode_errs = 0;

    // pixel table
    string entry_name [$];
    int    entry_frame [$];
    int    entry_x [$];
    int    entry_y [$];
    int    entry_lit [$];  // -1 when it depends on the random buttons
    int    entry_row [$];

    clock_gen u_clock (
        .clk_25mhz (clk_25mhz),
        .arst_n    (arst_n)
    );

    hex_panel_top uut (
        .clk_25mhz  (clk_25mhz),
        .arst_n     (arst_n),
        .btn        (btn),
        .led        (led),
        .lane0      (lane0),
        .lane1      (lane1),
        .lane2      (lane2),
        .lane3      (lane3),
        .wifi_gpio0 (wifi_gpio0)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // digit k of the status word for a button pattern and frame count
    function automatic logic [3:0] nibble_at(input int k, input logic [6:0] b, input int count);
        logic [31:0] c;
        c = count;
        nibble_at = 4'h0;
        if (k < 7)
        begin
            nibble_at = {3'b000, b[k]};
        end
        else if (k == 13)
        begin
            nibble_at = b[3:0];  // bits 55:52
        end
        else if (k == 14)
        begin
            nibble_at = {1'b0, b[6:4]};
        end
        else if ((k >= 16) && (k < 24))
        begin
            nibble_at = c[4 * (k - 16) +: 4];  // upper half of the 64-bit count stays zero
        end
        else if ((k >= 32) && (k < 40))
        begin
            nibble_at = c[4 * (k - 32) +: 4];
        end
    endfunction

    function automatic logic [23:0] widen565(input logic [15:0] c);
        return {c[15:11], {3{c[11]}}, c[10:5], {2{c[5]}}, c[4:0], {3{c[0]}}};
    endfunction

    // {blank, hsync, vsync} of a beam position from the panel porches
    function automatic logic [2:0] timing_levels(input int x, input int y);
        logic blank_l;
        logic hs_l;
        logic vs_l;
        blank_l = (x >= h_active) || (y >= v_active);
        hs_l = (x >= h_active + h_front) && (x < h_active + h_front + h_pulse);
        vs_l = (y >= v_active + v_front) && (y < v_active + v_front + v_pulse);
        return {blank_l, hs_l, vs_l};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual, output bit ok);
        check_count++;
        ok = (expected === actual);
        if (!ok)
        begin
            err_count++;
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0)
        begin
            tests_passed++;
            $display("[PASS] %s", name);
        end
        else
        begin
            tests_failed++;
            $display("[FAIL] %s with %0d mismatches", name, errs);
        end
    endtask

    task automatic add_entry(input string name, input int frame, input int x, input int y,
                             input int lit, input int row);
        entry_name.push_back(name);
        entry_frame.push_back(frame);
        entry_x.push_back(x);
        entry_y.push_back(y);
        entry_lit.push_back(lit);
        entry_row.push_back(row);
    endtask

    // entries in beam order with x = 12*col + 2*cx and y = 16*row + 2*cy
    task automatic load_table();
        add_entry("btn0_f0", 0, 2, 0, -1, 0);
        add_entry("cnt64_d0_f0", 0, 194, 0, 1, 0);
        add_entry("outside_right", 0, 384, 0, 0, 0);
        add_entry("hsync_pulse", 0, 520, 5, 0, 0);
        add_entry("outside_below", 0, 100, 32, 0, 0);
        add_entry("last_active", 0, 479, 271, 0, 0);
        add_entry("vsync_porch", 0, 10, 274, 0, 0);
        add_entry("btn3_f1", 1, 38, 0, -1, 0);
        add_entry("cnt64_d0_f1_unlit", 1, 192, 2, 0, 0);
        add_entry("cnt64_d0_f1", 1, 194, 2, 1, 0);
        add_entry("btn13_f1", 1, 160, 6, -1, 0);
        add_entry("gap_column", 1, 203, 6, 0, 0);
        add_entry("zero_digit_f1", 1, 100, 16, 1, 1);
        add_entry("btn6_f2", 2, 74, 0, -1, 0);
        add_entry("btn14_f2", 2, 170, 4, -1, 0);
        add_entry("cnt64_d1_f2", 2, 206, 6, 0, 0);
        add_entry("cnt32_d0_f2", 2, 8, 20, 1, 1);
        add_entry("cnt32_d1_f2", 2, 16, 22, 1, 1);
        add_entry("gap_row", 2, 2, 30, 0, 1);
    endtask

    task automatic check_idle_outputs(input string label, output int errs);
        bit ok;
        errs = 0;
        compare_value({label, " lanes"}, 32'd0, 32'({lane3, lane2, lane1, lane0}), ok);
        errs += int'(!ok);
        compare_value({label, " led[2:0]"}, 32'd0, 32'(led[2:0]), ok);
        errs += int'(!ok);
    endtask

    task automatic check_entry(input int i);
        int         hx;
        int         hy;
        int         cx;
        int         cy;
        int         s;
        int         now_pos;
        logic       lit;
        logic [4:0] grow;
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        logic [2:0] lv;
        logic [2:0] led_lv;
        logic       de;
        logic       hs;
        logic       vs;
        bit         ok;
        int         errs;
        hx = entry_x[i] >> scale_shift;
        hy = entry_y[i] >> scale_shift;
        cx = hx % cell_w;
        cy = hy % cell_h;
        s = entry_frame[i];
        lit = 1'b0;
        if ((entry_x[i] < text_w) && (entry_y[i] < text_h) && (cx < glyph_w) && (cy < glyph_h))
        begin
            grow = glyph_row(nibble_at((hy / cell_h) * digits_per_row + hx / cell_w,
                                       btn_hist[s], s), 3'(cy));
            lit = grow[glyph_w - 1 - cx];
        end
        if (entry_lit[i] >= 0)
        begin
            lit = (entry_lit[i] != 0);
        end
        {r8, g8, b8} = lit ? widen565(row_colour[entry_row[i]]) : 24'h0;
        lv = timing_levels(entry_x[i], entry_y[i]);
        de = !lv[2];
        hs = lv[1];
        vs = lv[0];
        // the beam has moved on by the lane latency when the lanes are read
        now_pos = entry_y[i] * h_total + entry_x[i] + out_delay;
        led_lv = timing_levels(now_pos % h_total, (now_pos / h_total) % v_total);
        errs = 0;
        compare_value({entry_name[i], " lane0"}, 32'({g8[0], r8[5:0]}), 32'(lane0), ok);
        errs += int'(!ok);
        compare_value({entry_name[i], " lane1"}, 32'({b8[1:0], g8[5:1]}), 32'(lane1), ok);
        errs += int'(!ok);
        compare_value({entry_name[i], " lane2"}, 32'({de, vs, hs, b8[5:2]}), 32'(lane2), ok);
        errs += int'(!ok);
        compare_value({entry_name[i], " lane3"},
                      32'({1'b0, b8[7:6], g8[7:6], r8[7:6]}), 32'(lane3), ok);
        errs += int'(!ok);
        compare_value({entry_name[i], " led[2:0]"}, 32'(led_lv), 32'(led[2:0]), ok);
        errs += int'(!ok);
        compare_value({entry_name[i], " led[7:3]"}, 32'(btn[4:0]), 32'(led[7:3]), ok);
        errs += int'(!ok);
        compare_value({entry_name[i], " wifi_gpio0"}, 32'(btn[0]), 32'(wifi_gpio0), ok);
        errs += int'(!ok);
        report_test(entry_name[i], errs);
    endtask

    // measures the sync and enable bits as a panel would see them
    task automatic decode_lane2();
        logic de;
        logic hs;
        logic vs;
        bit   ok;
        de = lane2[6];
        vs = lane2[5];
        hs = lane2[4];
        if (hs && !prev_hs)
        begin
            if (hs_rises > 0)
            begin
                compare_value("hsync period", 32'(h_total), 32'(hs_gap), ok);
                decode_errs += int'(!ok);
            end
            if (de_len != 0)
            begin
                compare_value("de clocks per line", 32'(h_active), 32'(de_len), ok);
                decode_errs += int'(!ok);
                de_lines++;
            end
            if (vs)
            begin
                vs_lines++;
            end
            hs_rises++;
            hs_gap = 0;
            hs_len = 0;
            de_len = 0;
        end
        if (!hs && prev_hs)
        begin
            compare_value("hsync width", 32'(h_pulse), 32'(hs_len), ok);
            decode_errs += int'(!ok);
        end
        if (vs && !prev_vs)
        begin
            compare_value("de lines per frame", 32'(v_active), 32'(de_lines), ok);
            decode_errs += int'(!ok);
            de_lines = 0;
        end
        if (!vs && prev_vs)
        begin
            compare_value("vsync lines", 32'(v_pulse), 32'(vs_lines), ok);
            decode_errs += int'(!ok);
            vs_lines = 0;
        end
        hs_gap++;
        hs_len += int'(hs);
        de_len += int'(de);
        prev_hs = hs;
        prev_vs = vs;
    endtask

    always @(posedge clk_25mhz)
    begin
        if (arst_n)
        begin
            cycle <= cycle + 1;
        end
    end

    always @(negedge clk_25mhz)
    begin
        if (arst_n && (cycle >= out_delay))
        begin
            decode_lane2();  // first lane word of the first frame onwards
        end
    end

    always @(posedge clk_25mhz)
    begin
        timeout_cnt++;
        if (timeout_cnt >= run_limit)
        begin
            $display("timeout after %0d cycles, the pixel table did not finish", run_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // a new pattern just after each snapshot is held for the whole frame
    initial
    begin
        btn = 7'd0;
        rng_state = 32'hf0704beb;
        forever
        begin
            @(posedge clk_25mhz);
            #2;
            if (arst_n && (cycle % frame_clocks == 1) && (cycle / frame_clocks < 4))
            begin
                rng_state = xorshift(rng_state);
                btn = rng_state[6:0];
                btn_hist[cycle / frame_clocks] = btn;
            end
        end
    end

    initial
    begin
        int reset_errs;
        int errs;
        int target;
        load_table();
        reset_errs = 0;
        @(negedge clk_25mhz);
        check_idle_outputs("in reset", errs);
        reset_errs += errs;
        wait (arst_n);
        repeat (out_delay)
        begin
            @(negedge clk_25mhz);
            check_idle_outputs("after reset", errs);
            reset_errs += errs;
        end
        report_test("reset_state", reset_errs);

        for (int i = 0; i < entry_name.size(); i++)
        begin
            target = (entry_frame[i] + 1) * frame_clocks + entry_y[i] * h_total
                     + entry_x[i] + out_delay;
            while (cycle < target)
            begin
                @(negedge clk_25mhz);
            end
            if (cycle != target)
            begin
                $display("table entry %s comes before the previous one in beam order",
                         entry_name[i]);
                tests_failed++;
            end
            else
            begin
                check_entry(i);
            end
        end

        if (hs_rises == 0)
        begin
            $display("no hsync pulse was decoded from lane2");
            tests_failed++;
        end
        else
        begin
            report_test("lane2_timing", decode_errs);
        end

        $display("tests: %0d passed, %0d failed, checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if ((err_count == 0) && (tests_failed == 0))
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hex_panel.f
+incdir+rtl
rtl/hex_panel_pkg.sv
rtl/panel_timing.sv
rtl/status_word.sv
rtl/hex_glyph_render.sv
rtl/lvds_lane_packer.sv
rtl/hex_panel_top.sv
bench/clock_gen.sv
bench/hex_panel_sva.sv
bench/hex_panel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hex_panel_tb -f hex_panel.f

out=$(./obj_dir/Vhex_panel_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
